/* logic/des_pkg.sv */
`default_nettype none

package des_pkg;

  ////////////////////
  // Widths and types
  ////////////////////
  localparam int BLOCK_W    = 64;
  localparam int HALF_W     = 32;
  localparam int CD_W       = 28;
  localparam int SUBKEY_W   = 48;
  localparam int NUM_ROUNDS = 16;

  typedef logic [BLOCK_W-1:0]  block_t;
  typedef logic [BLOCK_W-1:0]  key_t;
  typedef logic [HALF_W-1:0]   half_t;
  typedef logic [CD_W-1:0]     cd_half_t;
  typedef logic [SUBKEY_W-1:0] subkey_t;
  typedef logic [3:0]          round_t;

  ////////////////////
  // Permutation tables
  ////////////////////
  // Standard DES numbering, bit 1 is the MSB
  localparam byte unsigned IP_TABLE [1:64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,
    60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,
    64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1,
    59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,
    63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam byte unsigned IP_INV_TABLE [1:64] = '{
    40, 8, 48, 16, 56, 24, 64, 32,
    39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30,
    37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28,
    35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26,
    33, 1, 41,  9, 49, 17, 57, 25
  };

  localparam byte unsigned E_TABLE [1:48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  localparam byte unsigned P_TABLE [1:32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
  };

  // Parity bits 8, 16, ... 64 are dropped here
  localparam byte unsigned PC1_TABLE [1:56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  localparam byte unsigned PC2_TABLE [1:48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // Left rotation per round
  localparam byte unsigned SHIFT_TABLE [1:16] = '{
    1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
  };

  ////////////////////
  // S-boxes
  ////////////////////
  // Entry index is row * 16 + column
  localparam logic [3:0] SBOX_TABLE [1:8][0:63] = '{
    '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
      0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
      4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
      15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
    '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
      3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
      0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
      13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
    '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
      13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
      13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
      1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
    '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
      13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
      10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
      3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
    '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
      14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
      4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
      11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
    '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
      10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
      9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
      4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
    '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
      13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
      1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
      6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
    '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
      1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
      7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
      2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
  };

  ////////////////////
  // Helper functions
  ////////////////////
  function automatic block_t permute_ip(block_t din);
    block_t dout;
    for (int i = 1; i <= BLOCK_W; i++)
      dout[BLOCK_W-i] = din[BLOCK_W-IP_TABLE[i]];
    return dout;
  endfunction

  function automatic block_t permute_ip_inv(block_t din);
    block_t dout;
    for (int i = 1; i <= BLOCK_W; i++)
      dout[BLOCK_W-i] = din[BLOCK_W-IP_INV_TABLE[i]];
    return dout;
  endfunction

  function automatic subkey_t expand_e(half_t din);
    subkey_t dout;
    for (int i = 1; i <= SUBKEY_W; i++)
      dout[SUBKEY_W-i] = din[HALF_W-E_TABLE[i]];
    return dout;
  endfunction

  function automatic half_t permute_p(half_t din);
    half_t dout;
    for (int i = 1; i <= HALF_W; i++)
      dout[HALF_W-i] = din[HALF_W-P_TABLE[i]];
    return dout;
  endfunction

  function automatic logic [2*CD_W-1:0] permute_pc1(key_t din);
    logic [2*CD_W-1:0] dout;
    for (int i = 1; i <= 2 * CD_W; i++)
      dout[2*CD_W-i] = din[BLOCK_W-PC1_TABLE[i]];
    return dout;
  endfunction

  function automatic subkey_t permute_pc2(logic [2*CD_W-1:0] din);
    subkey_t dout;
    for (int i = 1; i <= SUBKEY_W; i++)
      dout[SUBKEY_W-i] = din[2*CD_W-PC2_TABLE[i]];
    return dout;
  endfunction

  // Row from bits 6 and 1, column from bits 5..2
  function automatic logic [3:0] sbox_lookup(int box, logic [5:0] bits);
    return SBOX_TABLE[box][{bits[5], bits[0], bits[4:1]}];
  endfunction

  function automatic half_t feistel_f(half_t r, subkey_t k);
    subkey_t x;
    half_t s;
    x = expand_e(r) ^ k;
    // S1 works on the top six bits
    for (int b = 1; b <= 8; b++)
      s[HALF_W-4*b +: 4] = sbox_lookup(b, x[SUBKEY_W-6*b +: 6]);
    return permute_p(s);
  endfunction

endpackage

`default_nettype wire

/* logic/des_block_load.sv */
`timescale 1ns/10ps
`default_nettype none

module des_block_load (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  logic               busy,
  input  des_pkg::block_t    message,
  input  des_pkg::key_t      key,
  output logic               load,
  output des_pkg::half_t     l0,
  output des_pkg::half_t     r0,
  output des_pkg::cd_half_t  c0,
  output des_pkg::cd_half_t  d0
);
  import des_pkg::*;

  logic              accept;
  block_t            ip_msg;
  logic [2*CD_W-1:0] pc1_key;

  // Only when idle and nothing pending
  assign accept  = start && !busy && !load;
  assign ip_msg  = permute_ip(message);
  assign pc1_key = permute_pc1(key);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      load <= 1'b0;
    else
      load <= accept;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      l0 <= ip_msg[BLOCK_W-1:HALF_W];
      r0 <= ip_msg[HALF_W-1:0];
      c0 <= pc1_key[2*CD_W-1:CD_W];
      d0 <= pc1_key[CD_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/des_key_schedule.sv */
`timescale 1ns/10ps
`default_nettype none

module des_key_schedule (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               load,
  input  logic               advance,
  input  des_pkg::cd_half_t  c0,
  input  des_pkg::cd_half_t  d0,
  input  des_pkg::round_t    round_idx,
  output des_pkg::subkey_t   subkey
);
  import des_pkg::*;

  cd_half_t c_q;
  cd_half_t d_q;
  cd_half_t c_rot;
  cd_half_t d_rot;
  logic     double_shift;

  assign double_shift = (SHIFT_TABLE[int'(round_idx) + 1] == 2);

  // Left rotation by one or two places
  always_comb
  begin
    if (double_shift)
    begin
      c_rot = {c_q[CD_W-3:0], c_q[CD_W-1:CD_W-2]};
      d_rot = {d_q[CD_W-3:0], d_q[CD_W-1:CD_W-2]};
    end
    else
    begin
      c_rot = {c_q[CD_W-2:0], c_q[CD_W-1]};
      d_rot = {d_q[CD_W-2:0], d_q[CD_W-1]};
    end
  end

  assign subkey = permute_pc2({c_rot, d_rot});

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      c_q <= '0;
      d_q <= '0;
    end
    else if (load)
    begin
      c_q <= c0;
      d_q <= d0;
    end
    else if (advance)
    begin
      c_q <= c_rot;
      d_q <= d_rot;
    end
  end

endmodule

`default_nettype wire

/* logic/des_round_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module des_round_engine (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load,
  input  des_pkg::half_t    l0,
  input  des_pkg::half_t    r0,
  input  des_pkg::subkey_t  subkey,
  output des_pkg::round_t   round_idx,
  output logic              advance,
  output logic              busy,
  output logic              finish,
  output des_pkg::half_t    l16,
  output des_pkg::half_t    r16
);
  import des_pkg::*;

  localparam round_t LAST_ROUND = round_t'(NUM_ROUNDS - 1);

  round_t round_q;
  half_t  l_q;
  half_t  r_q;
  half_t  f_out;

  assign f_out     = feistel_f(r_q, subkey);
  assign round_idx = round_q;
  assign advance   = busy;
  assign l16       = l_q;
  assign r16       = r_q;

  ////////////////////
  // Round control
  ////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy    <= 1'b0;
      round_q <= '0;
      finish  <= 1'b0;
    end
    else
    begin
      finish <= busy && (round_q == LAST_ROUND);
      if (load)
      begin
        busy    <= 1'b1;
        round_q <= '0;
      end
      else if (busy)
      begin
        round_q <= round_q + 1'b1;
        // Round 16 ends the block
        if (round_q == LAST_ROUND)
          busy <= 1'b0;
      end
    end
  end

  ////////////////////
  // Feistel halves
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      l_q <= l0;
      r_q <= r0;
    end
    else if (busy)
    begin
      l_q <= r_q;
      r_q <= l_q ^ f_out;
    end
  end

endmodule

`default_nettype wire

/* logic/des_block_out.sv */
`timescale 1ns/10ps
`default_nettype none

module des_block_out (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             finish,
  input  des_pkg::half_t   l16,
  input  des_pkg::half_t   r16,
  output des_pkg::block_t  ciphertext,
  output logic             done
);
  import des_pkg::*;

  block_t result;

  // Halves swap before the final permutation
  assign result = permute_ip_inv({r16, l16});

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ciphertext <= '0;
      done       <= 1'b0;
    end
    else
    begin
      done <= finish;
      if (finish)
        ciphertext <= result;
    end
  end

endmodule

`default_nettype wire

/* logic/des_encrypt_top.sv */
`timescale 1ns/10ps
`default_nettype none

module des_encrypt_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             start,
  input  des_pkg::block_t  message,
  input  des_pkg::key_t    key,
  output des_pkg::block_t  ciphertext,
  output logic             done
);
  import des_pkg::*;

  logic     load;
  logic     busy;
  logic     advance;
  logic     finish;
  half_t    l0;
  half_t    r0;
  half_t    l16;
  half_t    r16;
  cd_half_t c0;
  cd_half_t d0;
  round_t   round_idx;
  subkey_t  subkey;

  // Input side
  des_block_load load_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .busy    (busy),
    .message (message),
    .key     (key),
    .load    (load),
    .l0      (l0),
    .r0      (r0),
    .c0      (c0),
    .d0      (d0)
  );

  des_key_schedule key_sched_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .advance   (advance),
    .c0        (c0),
    .d0        (d0),
    .round_idx (round_idx),
    .subkey    (subkey)
  );

  des_round_engine engine_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .l0        (l0),
    .r0        (r0),
    .subkey    (subkey),
    .round_idx (round_idx),
    .advance   (advance),
    .busy      (busy),
    .finish    (finish),
    .l16       (l16),
    .r16       (r16)
  );

  // Output side
  des_block_out out_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .finish     (finish),
    .l16        (l16),
    .r16        (r16),
    .ciphertext (ciphertext),
    .done       (done)
  );

endmodule

`default_nettype wire

/* tb/des_tb_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module des_tb_sva (
  input logic            clk,
  input logic            arst_n,
  input logic            start,
  input logic            busy,
  input logic            load,
  input logic            done,
  input des_pkg::block_t ciphertext
);

  logic accepted;

  // Same acceptance rule as the input side
  assign accepted = start && !busy && !load;

  done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !done)
    else $error("done was high for two cycles in a row");

  // Done rises at the 18th edge and is first sampled high one edge later
  done_after_start: assert property (@(posedge clk) disable iff (!arst_n)
    $past(accepted, 19) |-> done)
    else $error("no done 18 cycles after an accepted start");

  start_before_done: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> $past(accepted, 19))
    else $error("done without an accepted start 18 cycles earlier");

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> (!done && ciphertext == '0))
    else $error("done or ciphertext active during reset");

endmodule

bind des_encrypt_top des_tb_sva sva_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .start      (start),
  .busy       (busy),
  .load       (load),
  .done       (done),
  .ciphertext (ciphertext)
);

`default_nettype wire

/* tb/des_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module des_tb;
  import des_pkg::*;

  localparam int NUM_VEC      = 4;
  localparam int LATENCY      = 18;
  localparam int DONE_TIMEOUT = 40;
  localparam int QUIET_CYCLES = 20;

  ////////////////////
  // Known-answer table
  ////////////////////
  localparam block_t MSG_TAB [0:NUM_VEC-1] = '{
    64'h0123456789ABCDEF, 64'h0000000000000000,
    64'h95F8A5E5DD31D900, 64'h8787878787878787
  };
  localparam key_t KEY_TAB [0:NUM_VEC-1] = '{
    64'h133457799BBCDFF1, 64'h0000000000000000,
    64'h0101010101010101, 64'h0E329232EA6D0D73
  };
  localparam block_t CT_TAB [0:NUM_VEC-1] = '{
    64'h85E813540F0AB405, 64'h8CA64DE9C1B123A7,
    64'h8000000000000000, 64'h0000000000000000
  };

  logic   clk;
  logic   arst_n;
  logic   start;
  block_t message;
  key_t   key;
  block_t ciphertext;
  logic   done;

  int     error_count;
  int     timeout_count;
  int     latency;
  int     gap;
  int     extra_done;
  bit     got_done;
  block_t last_ct;

  des_encrypt_top dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .message    (message),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done)
  );

  always #5 clk = ~clk;

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected)
    begin
      error_count++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Called on a falling edge; inputs are scrambled once start is gone
  task automatic send_start(input block_t msg, input key_t k);
    start   = 1'b1;
    message = msg;
    key     = k;
    @(negedge clk);
    start   = 1'b0;
    message = {$urandom, $urandom};
    key     = {$urandom, $urandom};
  endtask

  // Edges counted from the start edge; old result must hold meanwhile
  task automatic wait_done(input int edges_in, input block_t hold_ct,
                           output int edges, output bit seen);
    edges = edges_in;
    while (!done && edges < DONE_TIMEOUT)
    begin
      check(ciphertext, hold_ct, "ciphertext changed before done");
      @(negedge clk);
      edges++;
    end
    seen = done;
    if (!seen)
    begin
      timeout_count++;
      $display("ERROR: done did not arrive within %0d cycles of start", DONE_TIMEOUT);
    end
  endtask

  initial
  begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    start         = 1'b0;
    message       = '0;
    key           = '0;
    error_count   = 0;
    timeout_count = 0;
    last_ct       = '0;
    void'($urandom(32'h3be0bb19));

    ////////////////////
    // Reset
    ////////////////////
    repeat (4)
    begin
      @(negedge clk);
      check({63'd0, done}, 64'd0, "done during reset");
      check(ciphertext, 64'd0, "ciphertext during reset");
    end
    arst_n = 1'b1;
    // First clock edge out of reset
    @(negedge clk);
    check({63'd0, done}, 64'd0, "done just after reset");
    check(ciphertext, 64'd0, "ciphertext just after reset");

    ////////////////////
    // Table rows with random idle gaps
    ////////////////////
    for (int i = 0; i < NUM_VEC; i++)
    begin
      gap = $urandom % 6;
      repeat (gap)
      begin
        @(negedge clk);
        check(ciphertext, last_ct, "ciphertext changed while idle");
      end
      send_start(MSG_TAB[i], KEY_TAB[i]);
      wait_done(0, last_ct, latency, got_done);
      if (got_done)
      begin
        check(64'(latency), 64'(LATENCY), $sformatf("latency of row %0d", i));
        check(ciphertext, CT_TAB[i], $sformatf("ciphertext of row %0d", i));
        last_ct = CT_TAB[i];
        @(negedge clk);
        check({63'd0, done}, 64'd0, "done longer than one cycle");
      end
    end

    ////////////////////
    // Start while busy
    ////////////////////
    send_start(MSG_TAB[0], KEY_TAB[0]);
    repeat (4) @(negedge clk);
    // Lands on the fifth edge after the first start
    send_start(MSG_TAB[1], KEY_TAB[1]);
    wait_done(5, last_ct, latency, got_done);
    if (got_done)
    begin
      check(64'(latency), 64'(LATENCY), "latency with an ignored start");
      check(ciphertext, CT_TAB[0], "ciphertext with an ignored start");
      extra_done = 0;
      repeat (QUIET_CYCLES)
      begin
        @(negedge clk);
        if (done)
          extra_done++;
      end
      check(64'(extra_done), 64'd0, "done pulses after the ignored start");
      check(ciphertext, CT_TAB[0], "ciphertext after the ignored start");
    end

    $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/des_pkg.sv
logic/des_block_load.sv
logic/des_key_schedule.sv
logic/des_round_engine.sv
logic/des_block_out.sv
logic/des_encrypt_top.sv
tb/des_tb_sva.sv
tb/des_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the DES testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module des_tb \
  -Mdir "$BUILD_DIR" \
  -o des_sim
compile_status=$?
if [ $compile_status -ne 0 ]; then
  echo "Verilator compile failed with status $compile_status"
  exit 1
fi

"./$BUILD_DIR/des_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Testbench reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
